// File: bench/biss_encoder_model.sv
`timescale 1ns/100ps
`include "biss_params.svh"

// behavioral BiSS-C slave, answers MA with the loaded frame
module biss_encoder_model (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      ma,
  output logic                      slo,
  input  biss_frame_pkg::position_t frame_pos,
  input  biss_frame_pkg::error_t    frame_err,
  input  biss_frame_pkg::crc_t      frame_crc,  // true polarity
  input  logic                      corrupt,
  input  int                        flip_sel,   // crc bit to flip, 0..5
  input  int                        ack_len     // ack zeros, 1..3
);
  import biss_frame_pkg::*;

  localparam int tx_bits      = `BISS_DATA_BITS + 1;  // start bit + data
  localparam int timeout_clks = 20;

  crc_t               crc_line;
  logic [tx_bits-1:0] tx_word;
  logic [tx_bits-1:0] tx_shift;  // msb goes out next
  logic               ma_q;
  int                 rise_cnt;  // MA rises seen in this frame
  int                 hold_cnt;  // timeout clocks left

  assign crc_line = ~(corrupt ? (frame_crc ^ crc_t'(1 << flip_sel)) : frame_crc);
  assign tx_word  = {1'b1, {`BISS_CDS_BITS{1'b0}}, frame_pos, frame_err, crc_line};

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slo      <= 1'b1;  // ready
      ma_q     <= 1'b1;
      rise_cnt <= 0;
      hold_cnt <= 0;
      tx_shift <= '0;
    end else begin
      ma_q <= ma;
      if (hold_cnt != 0) begin
        hold_cnt <= hold_cnt - 1;
        if (hold_cnt == 1) begin
          slo      <= 1'b1;  // timeout over
          rise_cnt <= 0;
        end
      end else if (ma && !ma_q) begin
        rise_cnt <= rise_cnt + 1;
        if (rise_cnt < ack_len) begin
          slo <= 1'b0;                              // ack
        end else if (rise_cnt < ack_len + tx_bits) begin
          slo      <= tx_shift[tx_bits-1];
          tx_shift <= tx_shift << 1;
        end else begin
          slo      <= 1'b0;                         // MA parked, hold timeout
          hold_cnt <= timeout_clks;
        end
      end else if (rise_cnt == 0) begin
        tx_shift <= tx_word;                        // follow the load while idle
      end
    end
  end

endmodule

// File: bench/biss_master_tb.sv
`timescale 1ns/100ps
`include "biss_params.svh"

module biss_master_tb;
  import biss_frame_pkg::*;

  localparam int timeout_cycles = 60 * (40 * 2 * `BISS_HALF_DIV + 200);
  localparam int frame_falls    = 2 + `BISS_DATA_BITS;  // idle edge + start + data

  logic      clk = 1'b0;
  logic      rst_n;
  logic      request;
  logic      slo, ma, busy, frame_done, crc_err;
  position_t position;
  error_t    error;
  crc_t      crc_data;
  position_t enc_pos;       // encoder model load
  error_t    enc_err;
  crc_t      enc_crc;
  logic      enc_corrupt;
  int        enc_flip;
  int        enc_ack;
  int        seed = 51441;
  int        cycle_cnt = 0;
  int        errors = 0;      // field and handshake checks
  int        edge_errors = 0; // MA edges per frame
  int        mon_errors = 0;  // MA low while idle
  int        fall_cnt = 0;
  int        done_cnt = 0;
  int        tests_run = 0;
  logic      ma_q = 1'b1;

  biss_master dut (
    .clk(clk), .rst_n(rst_n), .request(request), .slo(slo), .ma(ma), .busy(busy),
    .frame_done(frame_done), .crc_err(crc_err), .position(position), .error(error),
    .crc_data(crc_data)
  );

  biss_encoder_model encoder (
    .clk(clk), .rst_n(rst_n), .ma(ma), .slo(slo), .frame_pos(enc_pos),
    .frame_err(enc_err), .frame_crc(enc_crc), .corrupt(enc_corrupt),
    .flip_sel(enc_flip), .ack_len(enc_ack)
  );

  always #10 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // watchdog and line monitor
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles) begin
      $display("timeout: the run did not end within %0d cycles", timeout_cycles);
      $display("Finished with errors");
      $finish;
    end
  end

  // outputs only move on posedge, look at them mid cycle
  always @(negedge clk) begin
    ma_q <= ma;
    if (ma_q && !ma) fall_cnt <= fall_cnt + 1;
    if (frame_done) done_cnt <= done_cnt + 1;
    if (rst_n && !busy) begin
      assert (ma) else begin
        $display("mismatch at %0t: MA low between frames", $time);
        mon_errors <= mon_errors + 1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  // remainder of pos * x^6 by long division, init 0
  function automatic crc_t crc6_by_division(input position_t pos);
    logic [`BISS_POS_BITS+`BISS_CRC_BITS-1:0] rem;
    logic [`BISS_POS_BITS+`BISS_CRC_BITS-1:0] divisor;
    rem     = {pos, {`BISS_CRC_BITS{1'b0}}};
    divisor = {{(`BISS_POS_BITS-1){1'b0}}, 1'b1, `BISS_CRC_POLY};
    for (int i = `BISS_POS_BITS + `BISS_CRC_BITS - 1; i >= `BISS_CRC_BITS; i--) begin
      if (rem[i]) rem = rem ^ (divisor << (i - `BISS_CRC_BITS));
    end
    return rem[`BISS_CRC_BITS-1:0];
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("mismatch at %0t: %s is %0h, expected %0h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errs);
    tests_run++;
    if (errs == 0) $display("test %0d %s: ok", tests_run, name);
    else $display("test %0d %s: %0d errors", tests_run, name, errs);
  endtask

  // one random frame, optional stray requests inside it
  task automatic run_frame(input logic corrupt, input logic extra_req);
    int        r;
    int        falls0;
    int        done0;
    int        ack;
    int        flip;
    position_t pos;
    error_t    err;
    crc_t      crc_good;
    crc_t      crc_sent;
    r        = $random(seed);
    pos      = r[`BISS_POS_BITS-1:0];
    r        = $random(seed);
    err      = r[`BISS_ERR_BITS-1:0];
    ack      = 1 + int'(r[9:8]) % 3;
    flip     = int'(r[14:12]) % 6;
    crc_good = crc6_by_division(pos);
    crc_sent = corrupt ? (crc_good ^ crc_t'(1 << flip)) : crc_good;
    @(posedge clk);
    enc_pos     <= pos;
    enc_err     <= err;
    enc_crc     <= crc_good;
    enc_corrupt <= corrupt;
    enc_flip    <= flip;
    enc_ack     <= ack;
    request     <= 1'b1;
    falls0 = fall_cnt;
    done0  = done_cnt;
    @(posedge clk);
    request <= 1'b0;
    if (extra_req) begin
      r = $random(seed);
      repeat (100 + int'(r[9:0])) @(posedge clk);  // lands in ack or data phase
      request <= 1'b1;
      @(posedge clk);
      request <= 1'b0;
    end
    do @(negedge clk); while (!frame_done);
    check_value("position", 32'(position), 32'(pos));
    check_value("error", 32'(error), 32'(err));
    check_value("crc_data", 32'(crc_data), 32'(crc_sent));
    check_value("crc_err", 32'(crc_err), 32'(corrupt));
    check_value("busy at frame_done", 32'(busy), 32'd1);   // timeout still running
    if (extra_req) begin
      @(posedge clk);
      request <= 1'b1;                                     // during encoder timeout
      @(posedge clk);
      request <= 1'b0;
    end
    do @(negedge clk); while (busy);
    check_value("slo as busy falls", 32'(slo), 32'd1);
    repeat (4) @(negedge clk);
    check_value("busy after frame", 32'(busy), 32'd0);
    check_value("frame_done count", 32'(done_cnt - done0), 32'd1);
    assert (fall_cnt - falls0 == ack + frame_falls) else begin
      $display("mismatch at %0t: %0d MA falling edges, expected %0d", $time,
               fall_cnt - falls0, ack + frame_falls);
      edge_errors++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int e0;
    rst_n       = 1'b0;
    request     = 1'b0;
    enc_pos     = '0;
    enc_err     = '0;
    enc_crc     = '0;
    enc_corrupt = 1'b0;
    enc_flip    = 0;
    enc_ack     = 1;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    e0 = errors;
    check_value("ma", 32'(ma), 32'd1);
    check_value("busy", 32'(busy), 32'd0);
    check_value("frame_done", 32'(frame_done), 32'd0);
    check_value("position", 32'(position), 32'd0);
    check_value("error", 32'(error), 32'd0);
    check_value("crc_data", 32'(crc_data), 32'd0);
    check_value("crc_err", 32'(crc_err), 32'd0);
    report_test("reset values", errors - e0);
    e0 = errors;
    repeat (40) run_frame(1'b0, 1'b0);
    report_test("clean frames", errors - e0);
    e0 = errors;
    repeat (10) run_frame(1'b1, 1'b0);
    report_test("corrupted frames", errors - e0);
    e0 = errors;
    repeat (5) run_frame(1'b0, 1'b1);
    report_test("request while busy", errors - e0);
    report_test("MA edge count", edge_errors + mon_errors);
    $display("%0d tests run, %0d errors", tests_run, errors + edge_errors + mon_errors);
    if (errors + edge_errors + mon_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: project.f
+incdir+source
source/biss_frame_pkg.sv
source/biss_link_pkg.sv
source/biss_bit_if.sv
source/biss_sequencer.sv
source/biss_field_capture.sv
source/biss_crc6.sv
source/biss_frame_check.sv
source/biss_master.sv
bench/biss_encoder_model.sv
bench/biss_master_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the BiSS master testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert \
  --top-module biss_master_tb \
  -f project.f \
  --Mdir "$build_dir" \
  -o biss_master_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/biss_master_tb" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Finished with errors" "$log_file"; then
  exit 1
fi
exit 0

// File: source/biss_bit_if.sv
`timescale 1ns/100ps

// sampled bit stream from the sequencer
// one producer, two listeners working side by side
interface biss_bit_if;
  import biss_frame_pkg::*;

  logic       bit_strobe;   // one cycle per sampled data bit
  logic       bit_value;    // synced slo level at the MA fall
  bit_index_t bit_index;    // 0 = cds, 34 = last crc bit
  logic       frame_start;  // start bit seen
  logic       frame_end;    // with the strobe of bit 34

  modport sequencer (
    output bit_strobe, bit_value, bit_index, frame_start, frame_end
  );

  // capture only needs the bits themselves
  modport capture (
    input bit_strobe, bit_value, bit_index
  );

  modport crc (
    input bit_strobe, bit_value, bit_index, frame_start, frame_end
  );

endinterface

// File: source/biss_crc6.sv
`timescale 1ns/100ps
`include "biss_params.svh"

module biss_crc6 (
  input  logic             clk,
  input  logic             rst_n,
  biss_bit_if.crc          bits,
  output biss_frame_pkg::crc_t crc_calc
);
  import biss_frame_pkg::*;

  localparam crc_t       crc_poly  = `BISS_CRC_POLY;
  localparam bit_index_t pos_first = bit_index_t'(`BISS_CDS_BITS);
  localparam bit_index_t pos_last  = bit_index_t'(`BISS_CDS_BITS + `BISS_POS_BITS - 1);

  crc_t lfsr;
  logic fb;         // top bit out xor incoming bit
  logic crc_bit;    // this strobe is a position bit

  //////////////////////////////////////////////////////////////////////
  // serial crc-6 msb first from zero
  //////////////////////////////////////////////////////////////////////

  // only the position word is covered
  assign crc_bit = bits.bit_strobe
                   && (bits.bit_index >= pos_first)
                   && (bits.bit_index <= pos_last);

  assign fb = lfsr[`BISS_CRC_BITS-1] ^ bits.bit_value;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lfsr <= '0;
    end else if (bits.frame_start) begin
      lfsr <= '0;                                   // new frame
    end else if (crc_bit) begin
      lfsr <= {lfsr[`BISS_CRC_BITS-2:0], 1'b0}
              ^ ({`BISS_CRC_BITS{fb}} & crc_poly);  // feedback taps
    end
    // error and crc bits leave it unchanged
  end

  // settled after bit 26 and read at frame end
  assign crc_calc = lfsr;

endmodule

// File: source/biss_field_capture.sv
`timescale 1ns/100ps
`include "biss_params.svh"

module biss_field_capture (
  input  logic                  clk,
  input  logic                  rst_n,
  biss_bit_if.capture           bits,
  output biss_frame_pkg::position_t position,
  output biss_frame_pkg::error_t    error,
  output biss_frame_pkg::crc_t      crc_rx
);
  import biss_frame_pkg::*;

  // index ranges of the fields after the start bit
  localparam bit_index_t pos_first = bit_index_t'(`BISS_CDS_BITS);
  localparam bit_index_t pos_last  = bit_index_t'(`BISS_CDS_BITS + `BISS_POS_BITS - 1);
  localparam bit_index_t err_last  = bit_index_t'(`BISS_CDS_BITS + `BISS_POS_BITS
                                                  + `BISS_ERR_BITS - 1);
  localparam bit_index_t idx_last  = bit_index_t'(`BISS_DATA_BITS - 1);

  logic in_pos;
  logic in_err;
  logic in_crc;

  assign in_pos = (bits.bit_index >= pos_first) && (bits.bit_index <= pos_last);
  assign in_err = (bits.bit_index > pos_last) && (bits.bit_index <= err_last);
  assign in_crc = (bits.bit_index > err_last);

  //////////////////////////////////////////////////////////////////////
  // field shift registers
  //////////////////////////////////////////////////////////////////////

  // every field arrives msb first and is fully refilled each frame,
  // so nothing needs clearing between frames
  always_ff @(posedge clk) begin
    if (bits.bit_strobe) begin
      if (in_pos) begin
        position <= {position[`BISS_POS_BITS-2:0], bits.bit_value};
      end
      if (in_err) begin
        error <= {error[`BISS_ERR_BITS-2:0], bits.bit_value};  // kept active low
      end
      if (in_crc) begin
        crc_rx <= {crc_rx[`BISS_CRC_BITS-2:0], ~bits.bit_value};  // undo line inversion
      end
      // index 0 is cds, dropped
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // sequencer must stop clocking after the last crc bit
  a_index_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    bits.bit_strobe |-> (bits.bit_index <= idx_last)
  ) else $error("bit index %0d past end of frame", bits.bit_index);

endmodule

// File: source/biss_frame_check.sv
`timescale 1ns/100ps

module biss_frame_check (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      frame_end,
  input  biss_frame_pkg::position_t position,
  input  biss_frame_pkg::error_t    error,
  input  biss_frame_pkg::crc_t      crc_rx,
  input  biss_frame_pkg::crc_t      crc_calc,
  output biss_frame_pkg::position_t position_out,
  output biss_frame_pkg::error_t    error_out,
  output biss_frame_pkg::crc_t      crc_out,
  output logic                      crc_err,
  output logic                      frame_done
);

  logic frame_end_q;  // last crc bit now in crc_rx

  //////////////////////////////////////////////////////////////////////
  // result registers
  //////////////////////////////////////////////////////////////////////

  // capture takes bit 34 on the edge after frame_end, wait one more
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frame_end_q  <= 1'b0;
      frame_done   <= 1'b0;
      position_out <= '0;
      error_out    <= '0;
      crc_out      <= '0;
      crc_err      <= 1'b0;
    end else begin
      frame_end_q <= frame_end;
      frame_done  <= frame_end_q;             // single pulse per frame
      if (frame_end_q) begin
        position_out <= position;
        error_out    <= error;
        crc_out      <= crc_rx;
        crc_err      <= (crc_rx != crc_calc);  // held until next frame
      end
    end
  end

  // frames are far apart, back to back done means a stuck end
  a_done_pulse: assert property (
    @(posedge clk) disable iff (!rst_n)
    frame_done |=> !frame_done
  ) else $error("frame_done high two cycles in a row");

endmodule

// File: source/biss_frame_pkg.sv
`include "biss_params.svh"

// types for the decoded frame contents
package biss_frame_pkg;

  // encoder angle, msb first on the line
  typedef logic [`BISS_POS_BITS-1:0] position_t;

  // error and warning bits as received
  // both active low, 2'b11 means all good
  typedef logic [`BISS_ERR_BITS-1:0] error_t;

  // crc word, true polarity once captured
  typedef logic [`BISS_CRC_BITS-1:0] crc_t;

  // bit number after the start bit
  //   0       cds
  //   1..26   position
  //   27..28  error / warning
  //   29..34  crc
  typedef logic [$clog2(`BISS_DATA_BITS)-1:0] bit_index_t;

endpackage

// File: source/biss_link_pkg.sv
`include "biss_params.svh"

// types for the line protocol side of the master
package biss_link_pkg;

  // frame sequencer states
  typedef enum logic [2:0] {
    seq_idle,   // MA parked high, waiting for request
    seq_ack,    // clocking, waiting for ack low
    seq_start,  // waiting for the start bit
    seq_data,   // cds, position, error, crc
    seq_stop    // MA high again, waiting out the timeout
  } seq_state_t;

  // counts sys clocks inside one MA half period
  typedef logic [`BISS_DIV_BITS-1:0] div_count_t;

endpackage

// File: source/biss_master.sv
`timescale 1ns/100ps

module biss_master (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      request,
  input  logic                      slo,
  output logic                      ma,
  output logic                      busy,
  output logic                      frame_done,
  output logic                      crc_err,
  output biss_frame_pkg::position_t position,
  output biss_frame_pkg::error_t    error,
  output biss_frame_pkg::crc_t      crc_data
);
  import biss_frame_pkg::*;

  position_t cap_position;  // live shift registers
  error_t    cap_error;
  crc_t      cap_crc_rx;
  crc_t      crc_calc;

  biss_bit_if bit_bus ();

  biss_sequencer u_sequencer (
    .clk     (clk),
    .rst_n   (rst_n),
    .request (request),
    .slo     (slo),
    .ma      (ma),
    .busy    (busy),
    .bits    (bit_bus.sequencer)
  );

  biss_field_capture u_capture (
    .clk      (clk),
    .rst_n    (rst_n),
    .bits     (bit_bus.capture),
    .position (cap_position),
    .error    (cap_error),
    .crc_rx   (cap_crc_rx)
  );

  biss_crc6 u_crc6 (
    .clk      (clk),
    .rst_n    (rst_n),
    .bits     (bit_bus.crc),
    .crc_calc (crc_calc)
  );

  biss_frame_check u_check (
    .clk          (clk),
    .rst_n        (rst_n),
    .frame_end    (bit_bus.frame_end),
    .position     (cap_position),
    .error        (cap_error),
    .crc_rx       (cap_crc_rx),
    .crc_calc     (crc_calc),
    .position_out (position),
    .error_out    (error),
    .crc_out      (crc_data),
    .crc_err      (crc_err),
    .frame_done   (frame_done)
  );

endmodule

// File: source/biss_params.svh
`ifndef BISS_PARAMS_SVH
`define BISS_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// line timing
//////////////////////////////////////////////////////////////////////

`define BISS_HALF_DIV   50      // sys clocks per MA half period
`define BISS_DIV_BITS   8       // width of the half period counter

//////////////////////////////////////////////////////////////////////
// frame layout
//////////////////////////////////////////////////////////////////////

`define BISS_CDS_BITS   1       // cds bit right after start
`define BISS_POS_BITS   26      // single turn angle
`define BISS_ERR_BITS   2       // error + warning, active low
`define BISS_CRC_BITS   6       // crc sent inverted

// everything sampled after the start bit
`define BISS_DATA_BITS  35

//////////////////////////////////////////////////////////////////////
// crc
//////////////////////////////////////////////////////////////////////

`define BISS_CRC_POLY   6'h03   // x^6 + x + 1, x^6 implied

`endif

// File: source/biss_sequencer.sv
`timescale 1ns/100ps
`include "biss_params.svh"

module biss_sequencer (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          request,  // single cycle pulse ignored unless idle
  input  logic          slo,      // async encoder data line
  output logic          ma,       // encoder clock line idling high
  output logic          busy,
  biss_bit_if.sequencer bits
);
  import biss_frame_pkg::*;
  import biss_link_pkg::*;

  localparam div_count_t div_last = div_count_t'(`BISS_HALF_DIV - 1);
  localparam bit_index_t idx_last = bit_index_t'(`BISS_DATA_BITS - 1);

  seq_state_t state;
  seq_state_t state_nxt;
  div_count_t div_cnt;      // position inside the half period
  bit_index_t idx_cnt;      // next data bit to be sampled
  logic [1:0] slo_sync;     // [1] is the synced level
  logic       slo_prev;     // for the timeout release edge
  logic       div_run;
  logic       div_tick;
  logic       ma_fall;
  logic       slo_rise;

  //////////////////////////////////////////////////////////////////////
  // slo synchronizer
  //////////////////////////////////////////////////////////////////////

  // line idles high so reset to 1 and avoid a fake rise
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slo_sync <= 2'b11;
      slo_prev <= 1'b1;
    end else begin
      slo_sync <= {slo_sync[0], slo};
      slo_prev <= slo_sync[1];
    end
  end

  assign slo_rise = slo_sync[1] & ~slo_prev;  // encoder timeout over

  //////////////////////////////////////////////////////////////////////
  // MA clock
  //////////////////////////////////////////////////////////////////////

  assign div_run  = (state != seq_idle) && (state != seq_stop);
  assign div_tick = (div_cnt == div_last);
  assign ma_fall  = div_run && div_tick && ma;  // MA about to go low

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt <= '0;
      ma      <= 1'b1;
    end else if (!div_run) begin
      div_cnt <= '0;
      ma      <= 1'b1;                          // park high
    end else if (div_tick) begin
      div_cnt <= '0;
      ma      <= ~ma;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // frame FSM
  //////////////////////////////////////////////////////////////////////

  // all line samples taken on the synced level at the MA fall
  always_comb begin
    state_nxt = state;
    case (state)
      seq_idle:  if (request) state_nxt = seq_ack;
      seq_ack:   if (ma_fall && !slo_sync[1]) state_nxt = seq_start;
      seq_start: if (ma_fall && slo_sync[1]) state_nxt = seq_data;
      seq_data:  if (ma_fall && idx_cnt == idx_last) state_nxt = seq_stop;
      seq_stop:  if (slo_rise) state_nxt = seq_idle;
      default:   state_nxt = seq_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state            <= seq_idle;
      idx_cnt          <= '0;
      bits.bit_strobe  <= 1'b0;
      bits.frame_start <= 1'b0;
      bits.frame_end   <= 1'b0;
    end else begin
      state            <= state_nxt;
      bits.bit_strobe  <= (state == seq_data) && ma_fall;
      bits.frame_start <= (state == seq_start) && ma_fall && slo_sync[1];
      bits.frame_end   <= (state == seq_data) && ma_fall && (idx_cnt == idx_last);
      if (state == seq_start) begin
        idx_cnt <= '0;                          // cds comes first
      end else if (state == seq_data && ma_fall) begin
        idx_cnt <= idx_cnt + 1'b1;
      end
    end
  end

  // payload taken at every MA fall and read only with the strobe
  always_ff @(posedge clk) begin
    if (ma_fall) begin
      bits.bit_value <= slo_sync[1];
      bits.bit_index <= idx_cnt;
    end
  end

  assign busy = (state != seq_idle);

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // strobe is registered so the last one already sees seq_stop with frame_end
  a_strobe_in_data: assert property (
    @(posedge clk) disable iff (!rst_n)
    bits.bit_strobe |-> (state == seq_data) || (state == seq_stop && bits.frame_end)
  ) else $error("bit strobe outside of data phase");

  a_ma_idle_high: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state == seq_idle) |-> ma
  ) else $error("MA low while idle");

endmodule
